//--- hw/filter_types_pkg.sv
// Vector types for the biquad datapath
// Samples, coefficients, products, accumulator and coefficient addressing
`default_nettype none

package filter_types_pkg;

    // Datapath widths
    localparam int SAMPLE_W  = 24;
    localparam int COEF_W    = 16;
    // Full-precision sample times coefficient
    localparam int PRODUCT_W = SAMPLE_W + COEF_W;
    // Headroom for the sum of five products
    localparam int ACC_W     = PRODUCT_W + 2;

    // Signed audio sample
    typedef logic signed [SAMPLE_W-1:0]  sample_t;
    // Signed Q2.14 coefficient
    typedef logic signed [COEF_W-1:0]    coef_t;
    // Sample times coefficient
    typedef logic signed [PRODUCT_W-1:0] product_t;
    // Sum of the five section products
    typedef logic signed [ACC_W-1:0]     acc_t;

    // Coefficient index within a section
    typedef logic [2:0] coef_addr_t;
    // Section number
    typedef logic [0:0] section_sel_t;

endpackage

`default_nettype wire

//--- hw/filter_cfg_pkg.sv
// Cascade configuration constants
// Section count, coefficient scaling, index codes and saturation limits
`default_nettype none

package filter_cfg_pkg;

    // Number of biquad sections in the chain
    localparam int NUM_SECTIONS = 2;

    // Q2.14 coefficient scaling
    localparam int unsigned COEF_FRAC_BITS = 14;
    localparam filter_types_pkg::coef_t COEF_UNITY = 16'sd16384;

    // Coefficient index codes within one section
    // codes 5 to 7 are unused and dropped on write
    localparam filter_types_pkg::coef_addr_t COEF_B0 = 3'd0;
    localparam filter_types_pkg::coef_addr_t COEF_B1 = 3'd1;
    localparam filter_types_pkg::coef_addr_t COEF_B2 = 3'd2;
    localparam filter_types_pkg::coef_addr_t COEF_A1 = 3'd3;
    localparam filter_types_pkg::coef_addr_t COEF_A2 = 3'd4;

    // Saturation limits of a 24-bit signed sample
    localparam filter_types_pkg::sample_t SAMPLE_MAX = 24'sh7FFFFF;
    // Most negative value, -8388608
    localparam filter_types_pkg::sample_t SAMPLE_MIN = 24'sh800000;

endpackage

`default_nettype wire

//--- hw/coef_if.sv
// Coefficient set of one biquad section
// Source side is the coefficient bank, sink side is the section
`default_nettype none

interface coef_if;
    import filter_types_pkg::*;

    // Feed-forward taps
    coef_t b0;
    coef_t b1;
    coef_t b2;
    // Feedback taps, subtracted in the section
    coef_t a1;
    coef_t a2;

    // Bank drives the set
    modport source (output b0, b1, b2, a1, a2);

    // Section only reads it
    modport sink (input b0, b1, b2, a1, a2);

endinterface

`default_nettype wire

//--- hw/coef_bank.sv
// Coefficient register bank for all cascade sections
// Strobed word writes, pass-through set after reset
`default_nettype none

module coef_bank (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           coef_wr,
    input  filter_types_pkg::section_sel_t coef_section,
    input  filter_types_pkg::coef_addr_t   coef_index,
    input  filter_types_pkg::coef_t        coef_data,
    coef_if.source                         coefs_0,
    coef_if.source                         coefs_1
);
    import filter_types_pkg::*;
    import filter_cfg_pkg::*;

    // One register per tap per section
    coef_t b0_r [NUM_SECTIONS];
    coef_t b1_r [NUM_SECTIONS];
    coef_t b2_r [NUM_SECTIONS];
    coef_t a1_r [NUM_SECTIONS];
    coef_t a2_r [NUM_SECTIONS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // Unity b0, all other taps zero
            for (int s = 0; s < NUM_SECTIONS; s++) begin
                b0_r[s] <= COEF_UNITY;
                b1_r[s] <= '0;
                b2_r[s] <= '0;
                a1_r[s] <= '0;
                a2_r[s] <= '0;
            end
        end else if (coef_wr) begin
            // Section picks the row, index picks the tap
            case (coef_index)
                COEF_B0: b0_r[coef_section] <= coef_data;
                COEF_B1: b1_r[coef_section] <= coef_data;
                COEF_B2: b2_r[coef_section] <= coef_data;
                COEF_A1: a1_r[coef_section] <= coef_data;
                COEF_A2: a2_r[coef_section] <= coef_data;
                default: begin
                    // Unused codes leave every tap as it was
                end
            endcase
        end
    end

    // Section 0 set
    assign coefs_0.b0 = b0_r[0];
    assign coefs_0.b1 = b1_r[0];
    assign coefs_0.b2 = b2_r[0];
    assign coefs_0.a1 = a1_r[0];
    assign coefs_0.a2 = a2_r[0];

    // Section 1 set
    assign coefs_1.b0 = b0_r[1];
    assign coefs_1.b1 = b1_r[1];
    assign coefs_1.b2 = b2_r[1];
    assign coefs_1.a1 = a1_r[1];
    assign coefs_1.a2 = a2_r[1];

endmodule

`default_nettype wire

//--- hw/biquad_section.sv
// Direct-form-I biquad section, one result per sample strobe
// Q2.14 scaling, saturation to 24 bits, history moves only on a strobe
`default_nettype none

module biquad_section (
    input  logic                      clk,
    input  logic                      reset,
    coef_if.sink                      coefs,
    input  logic                      in_valid,
    input  filter_types_pkg::sample_t in_sample,
    output logic                      out_valid,
    output filter_types_pkg::sample_t out_sample
);
    import filter_types_pkg::*;
    import filter_cfg_pkg::*;

    // Input history x[n-1], x[n-2]
    sample_t  x1;
    sample_t  x2;
    // Output history y[n-1], y[n-2], saturated values
    sample_t  y1;
    sample_t  y2;

    product_t b0_x0;
    product_t b1_x1;
    product_t b2_x2;
    product_t a1_y1;
    product_t a2_y2;

    acc_t     acc;
    acc_t     acc_scaled;
    // Clamped result for this sample
    sample_t  y0;

    // Full-precision products, both operands signed
    assign b0_x0 = coefs.b0 * in_sample;
    assign b1_x1 = coefs.b1 * x1;
    assign b2_x2 = coefs.b2 * x2;
    assign a1_y1 = coefs.a1 * y1;
    assign a2_y2 = coefs.a2 * y2;

    // Sign-extended sum, feedback taps subtracted
    assign acc = acc_t'(b0_x0)
               + acc_t'(b1_x1)
               + acc_t'(b2_x2)
               - acc_t'(a1_y1)
               - acc_t'(a2_y2);

    // Drop the Q2.14 fraction, rounds toward minus infinity
    assign acc_scaled = acc >>> COEF_FRAC_BITS;

    // Saturate instead of wrapping
    always_comb begin
        if (acc_scaled > acc_t'(SAMPLE_MAX)) begin
            y0 = SAMPLE_MAX;
        end else if (acc_scaled < acc_t'(SAMPLE_MIN)) begin
            y0 = SAMPLE_MIN;
        end else begin
            y0 = sample_t'(acc_scaled);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid  <= 1'b0;
            out_sample <= '0;
            x1         <= '0;
            x2         <= '0;
            y1         <= '0;
            y2         <= '0;
        end else begin
            // Output strobe is the input strobe one cycle later
            out_valid <= in_valid;
            if (in_valid) begin
                out_sample <= y0;
                // Shift both histories
                x2 <= x1;
                x1 <= in_sample;
                y2 <= y1;
                // clamped value is what feeds back
                y1 <= y0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/biquad_cascade_top.sv
// Two-section biquad cascade top level
// Coefficient bank feeding two chained sections, latency of 2 cycles
`default_nettype none

module biquad_cascade_top (
    input  logic               clk,
    input  logic               reset,
    // Audio sample strobe and data
    input  logic               sample_valid,
    input  logic signed [23:0] sample_in,
    // Coefficient write port
    input  logic               coef_wr,
    input  logic        [0:0]  coef_section,
    input  logic        [2:0]  coef_index,
    input  logic signed [15:0] coef_data,
    // Filtered output, strobe 2 cycles after sample_valid
    output logic               out_valid,
    output logic signed [23:0] sample_out
);
    import filter_types_pkg::*;

    // Link from section 0 to section 1
    logic    mid_valid;
    sample_t mid_sample;

    // One coefficient set per section
    coef_if coefs_0 ();
    coef_if coefs_1 ();

    coef_bank coef_bank_inst (
        .clk          (clk),
        .reset        (reset),
        .coef_wr      (coef_wr),
        .coef_section (coef_section),
        .coef_index   (coef_index),
        .coef_data    (coef_data),
        .coefs_0      (coefs_0.source),
        .coefs_1      (coefs_1.source)
    );

    // First stage
    biquad_section section_0_inst (
        .clk        (clk),
        .reset      (reset),
        .coefs      (coefs_0.sink),
        .in_valid   (sample_valid),
        .in_sample  (sample_in),
        .out_valid  (mid_valid),
        .out_sample (mid_sample)
    );

    // Second stage runs on the first stage's strobe
    biquad_section section_1_inst (
        .clk        (clk),
        .reset      (reset),
        .coefs      (coefs_1.sink),
        .in_valid   (mid_valid),
        .in_sample  (mid_sample),
        .out_valid  (out_valid),
        .out_sample (sample_out)
    );

endmodule

`default_nettype wire

//--- tb/biquad_cascade_assertions.sv
// Concurrent checks on the cascade output strobe and reset state
// Bound to the cascade top level
`default_nettype none

module biquad_cascade_assertions (
    input logic               clk,
    input logic               reset,
    input logic               sample_valid,
    input logic               out_valid,
    input logic signed [23:0] sample_out
);
    timeunit 1ns;
    timeprecision 1ns;

    // Failed checks so far, polled by the testbench
    int error_count = 0;

    // A strobe in always comes out 2 cycles later
    strobe_latency: assert property (@(posedge clk) disable iff (reset)
        $past(sample_valid, 2) |-> out_valid)
        else begin
            error_count++;
            $error("out_valid missing 2 cycles after sample_valid");
        end

    // No output strobe without a matching input strobe
    no_spurious_out: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> $past(sample_valid, 2))
        else begin
            error_count++;
            $error("out_valid without sample_valid 2 cycles earlier");
        end

    // Output cleared while reset is held
    reset_outputs: assert property (@(posedge clk)
        reset |-> (!out_valid && sample_out == 24'sd0))
        else begin
            error_count++;
            $error("Outputs not cleared during reset");
        end

endmodule

`default_nettype wire

//--- tb/biquad_cascade_tb.sv
// Testbench for the two-section biquad cascade
// Test table, LFSR stimulus, bit-exact reference model, output checks, watchdog
`default_nettype none

module biquad_cascade_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import filter_types_pkg::*;
    import filter_cfg_pkg::*;

    localparam int NUM_ROWS      = 7;
    // Reset, coefficient writes and drain per row
    localparam int ROW_OVERHEAD  = 40;
    localparam int MARGIN_CYCLES = 200;
    localparam logic [15:0] LFSR_SEED = 16'd16052;
    // Stimulus kinds
    localparam int KIND_IMPULSE = 0;
    localparam int KIND_STEP    = 1;
    localparam int KIND_RANDOM  = 2;
    localparam int KIND_SQUARE  = 3;

    // Starts low with no edge at time zero
    logic         clk = 1'b0;
    logic         reset;
    logic         sample_valid;
    sample_t      sample_in;
    logic         coef_wr;
    section_sel_t coef_section;
    coef_addr_t   coef_index;
    coef_t        coef_data;
    logic         out_valid;
    sample_t      sample_out;

    // Test table, one entry per row
    string  row_name  [NUM_ROWS];
    longint row_coef  [NUM_ROWS][10];
    int     row_count [NUM_ROWS];
    int     row_kind  [NUM_ROWS];
    int     row_gap   [NUM_ROWS];
    logic   table_ready = 1'b0;
    int     cur_row;

    // Model history per section
    longint m_x1 [2];
    longint m_x2 [2];
    longint m_y1 [2];
    longint m_y2 [2];
    sample_t     expected [$];
    sample_t     exp_value;
    logic [15:0] lfsr_state;

    biquad_cascade_top biquad_cascade_top_inst (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample_in    (sample_in),
        .coef_wr      (coef_wr),
        .coef_section (coef_section),
        .coef_index   (coef_index),
        .coef_data    (coef_data),
        .out_valid    (out_valid),
        .sample_out   (sample_out)
    );

    bind biquad_cascade_top biquad_cascade_assertions assertions_inst (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .out_valid    (out_valid),
        .sample_out   (sample_out)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic set_row(input int r, input string name,
                           input longint c0, c1, c2, c3, c4, c5, c6, c7, c8, c9,
                           input int count, input int kind, input int gap);
        row_name[r]  = name;
        row_coef[r]  = '{c0, c1, c2, c3, c4, c5, c6, c7, c8, c9};
        row_count[r] = count;
        row_kind[r]  = kind;
        row_gap[r]   = gap;
    endtask

    // Columns: name, b0 b1 b2 a1 a2 of section 0, same for section 1, count, kind, gap
    task automatic load_table();
        set_row(0, "reset_passthru", 16384, 0, 0, 0, 0, 16384, 0, 0, 0, 0,
                24, KIND_RANDOM, 1);
        set_row(1, "lowpass_impulse", 1024, 2048, 1024, -24000, 9000,
                1024, 2048, 1024, -24000, 9000, 30, KIND_IMPULSE, 0);
        set_row(2, "lowpass_step", 1024, 2048, 1024, -24000, 9000,
                1024, 2048, 1024, -24000, 9000, 30, KIND_STEP, 2);
        set_row(3, "random_gap0", 1024, 2048, 1024, -24000, 9000,
                8192, -4096, 2048, 4096, -2048, 40, KIND_RANDOM, 0);
        set_row(4, "random_gap3", 1024, 2048, 1024, -24000, 9000,
                8192, -4096, 2048, 4096, -2048, 40, KIND_RANDOM, 3);
        // b0 near 2.0 plus positive feedback drives the output into the rails
        set_row(5, "gain_square", 32000, 0, 0, -8192, 0, 16384, 0, 0, 0, 0,
                24, KIND_SQUARE, 0);
        set_row(6, "sec1_rewrite", 8192, -4096, 2048, 4096, -2048,
                16384, 0, 0, 0, 0, 24, KIND_RANDOM, 1);
    endtask

    function automatic int watchdog_cycles();
        int total;
        total = MARGIN_CYCLES;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += row_count[r] * (1 + row_gap[r]) + ROW_OVERHEAD;
        end
        return total;
    endfunction

    // Galois LFSR, taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end else begin
            return state >> 1;
        end
    endfunction

    task automatic draw_random(output sample_t value);
        value = '0;
        for (int b = 0; b < 24; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[22:0], lfsr_state[0]};
        end
    endtask

    task automatic make_stimulus(input int kind, input int i, output sample_t value);
        case (kind)
            KIND_IMPULSE: value = (i == 0) ? 24'sd1000000 : 24'sd0;
            KIND_STEP:    value = 24'sd400000;
            KIND_RANDOM:  draw_random(value);
            // Four samples at the top rail, four at the bottom
            default:      value = i[2] ? SAMPLE_MIN : SAMPLE_MAX;
        endcase
    endtask

    // One section: sum of products, floor shift by 14, clamp, saturated feedback
    function automatic longint section_model(input int s, input longint x);
        longint acc;
        longint y;
        acc = row_coef[cur_row][5*s] * x + row_coef[cur_row][5*s+1] * m_x1[s]
            + row_coef[cur_row][5*s+2] * m_x2[s] - row_coef[cur_row][5*s+3] * m_y1[s]
            - row_coef[cur_row][5*s+4] * m_y2[s];
        y = acc >>> 14;
        if (y > longint'(SAMPLE_MAX)) begin
            y = longint'(SAMPLE_MAX);
        end else if (y < longint'(SAMPLE_MIN)) begin
            y = longint'(SAMPLE_MIN);
        end
        m_x2[s] = m_x1[s];
        m_x1[s] = x;
        m_y2[s] = m_y1[s];
        m_y1[s] = y;
        return y;
    endfunction

    function automatic sample_t model_cascade(input sample_t x);
        longint mid;
        mid = section_model(0, longint'(x));
        return sample_t'(section_model(1, mid));
    endfunction

    task automatic apply_reset();
        reset = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        for (int s = 0; s < 2; s++) begin
            m_x1[s] = 0;
            m_x2[s] = 0;
            m_y1[s] = 0;
            m_y2[s] = 0;
        end
    endtask

    task automatic write_word(input logic sec, input logic [2:0] idx, input logic [15:0] data);
        coef_wr      = 1'b1;
        coef_section = sec;
        coef_index   = idx;
        coef_data    = data;
        @(negedge clk);
        coef_wr = 1'b0;
    endtask

    task automatic write_coefs(input int r);
        // Section 0 taps first, then section 1
        for (int k = 0; k < 10; k++) begin
            write_word(k >= 5, 3'(k % 5), 16'(row_coef[r][k]));
        end
        // Unused codes 5 to 7 on section 1
        for (int c = 5; c < 8; c++) begin
            write_word(1'b1, 3'(c), 16'sh7FFF);
        end
    endtask

    task automatic run_row(input int r);
        sample_t stim;
        cur_row = r;
        apply_reset();
        // Row 0 runs on the pass-through set loaded by reset
        if (r != 0) begin
            write_coefs(r);
        end
        lfsr_state = LFSR_SEED;
        for (int i = 0; i < row_count[r]; i++) begin
            make_stimulus(row_kind[r], i, stim);
            expected.push_back(model_cascade(stim));
            sample_valid = 1'b1;
            sample_in    = stim;
            @(negedge clk);
            sample_valid = 1'b0;
            repeat (row_gap[r]) @(negedge clk);
        end
        // Drain the pipeline, watchdog covers a missing strobe
        while (expected.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    // Outputs settle after the rising edge, compare at the falling edge
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            assert (expected.size() != 0)
                else stop_with_failure($sformatf("%s: out_valid high with no sample pending",
                                                 row_name[cur_row]));
            exp_value = expected.pop_front();
            assert (sample_out == exp_value)
                else stop_with_failure($sformatf("Mismatch in %s: expected %0d, actual %0d",
                                                 row_name[cur_row], exp_value, sample_out));
        end
    end

    always @(negedge clk) begin
        assert (biquad_cascade_top_inst.assertions_inst.error_count == 0)
            else stop_with_failure("A bound assertion on strobe timing or reset state failed");
    end

    initial begin
        wait (table_ready);
        repeat (watchdog_cycles()) @(posedge clk);
        stop_with_failure("Timeout: the run did not finish within its cycle budget");
    end

    initial begin
        reset        = 1'b1;
        sample_valid = 1'b0;
        sample_in    = '0;
        coef_wr      = 1'b0;
        coef_section = '0;
        coef_index   = '0;
        coef_data    = '0;
        cur_row      = 0;
        load_table();
        table_ready = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        if (biquad_cascade_top_inst.assertions_inst.error_count != 0) begin
            stop_with_failure("A bound assertion failed at the end of the run");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
hw/filter_types_pkg.sv
hw/filter_cfg_pkg.sv
hw/coef_if.sv
hw/coef_bank.sv
hw/biquad_section.sv
hw/biquad_cascade_top.sv
tb/biquad_cascade_assertions.sv
tb/biquad_cascade_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the biquad cascade testbench with Verilator, run it, check the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -j 0 --top-module biquad_cascade_tb -f filelist.f \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vbiquad_cascade_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "^TESTBENCH PASSED$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
